// ==== src/dnc_pkg.sv ====
// Shared definitions for the DNC memory-update block
//   Q8.8 widths and fixed-point constants
//   Index and size widths for row and column capacity
//   Vector write and memory element structs
//   Control FSM state encoding

package dnc_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////

  // Q8.8 value and its exact product
  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 8;
  localparam int PROD_W    = 2 * DATA_W;

  // 1.0 in Q8.8
  localparam int ONE_Q = 256;

  // Capacity of the vector buffer
  localparam int MAX_N = 32;
  localparam int MAX_W = 16;

  // Index or size, must hold MAX_N itself
  localparam int INDEX_W = 6;

  // Array address bits actually decoded
  localparam int ROW_ADDR_W = $clog2(MAX_N);
  localparam int COL_ADDR_W = $clog2(MAX_W);

  // Element counter, holds N*W
  localparam int COUNT_W = 2 * INDEX_W;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic [INDEX_W-1:0]       index_t;

  // Target of a vector buffer write
  typedef enum logic [1:0] {
    VEC_W = 2'd0,
    VEC_E = 2'd1,
    VEC_V = 2'd2
  } vec_sel_e;

  typedef struct packed {
    logic     wr;
    vec_sel_e sel;
    index_t   addr;
    data_t    data;
  } vec_write_t;

  // One memory element with its coordinates
  typedef struct packed {
    logic   valid;
    logic   row_start;
    data_t  m;
    index_t j;
    index_t k;
  } element_t;

  typedef enum logic [1:0] {
    IDLE_STATE   = 2'd0,
    LOAD_STATE   = 2'd1,
    UPDATE_STATE = 2'd2
  } ctrl_state_e;

endpackage

// ==== src/dnc_matrix_ctrl.sv ====
// Control FSM of the DNC memory-update block
//   Latches N and W on START
//   Turns w, e, v strobes into vector buffer writes
//   Tracks row and column of the streamed matrix
//   Counts issued elements and raises READY on the last output

`timescale 1ns/1ps

module dnc_matrix_ctrl
  import dnc_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,

  input  logic       START,
  input  logic       W_IN_J_ENABLE,
  input  logic       E_IN_K_ENABLE,
  input  logic       V_IN_K_ENABLE,
  input  logic       M_IN_J_ENABLE,
  input  logic       M_IN_K_ENABLE,
  input  data_t      W_IN,
  input  data_t      E_IN,
  input  data_t      V_IN,
  input  data_t      M_IN,
  input  index_t     SIZE_N_IN,
  input  index_t     SIZE_W_IN,
  input  logic       out_done,

  output vec_write_t vec_write,
  output element_t   element,
  output logic       READY
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ctrl_state_e        state;
  index_t             size_n;
  index_t             size_w;
  index_t             w_cnt;
  index_t             e_cnt;
  index_t             v_cnt;
  index_t             row_idx;
  index_t             col_idx;
  logic               first_row;
  logic [COUNT_W-1:0] elem_cnt;
  logic [COUNT_W-1:0] elem_total;
  // Last element issue, delayed to line up with its output
  logic [1:0]         last_pipe;

  logic               in_load;
  logic               in_update;
  logic               load_done;
  logic               w_take;
  logic               e_take;
  logic               v_take;
  logic               row_start;
  logic               elem_valid;
  logic               last_issue;
  index_t             cur_j;
  index_t             cur_k;

  ////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////

  assign in_load    = (state == LOAD_STATE);
  assign in_update  = (state == UPDATE_STATE);
  assign elem_total = size_n * size_w;
  assign load_done  = (w_cnt == size_n) && (e_cnt == size_w) && (v_cnt == size_w);

  // One buffer write per cycle, w first, then e, then v
  assign w_take = in_load && W_IN_J_ENABLE && (w_cnt != size_n);
  assign e_take = in_load && E_IN_K_ENABLE && (e_cnt != size_w) && !w_take;
  assign v_take = in_load && V_IN_K_ENABLE && (v_cnt != size_w) && !w_take && !e_take;

  always_comb begin
    vec_write.wr = w_take || e_take || v_take;
    if (w_take) begin
      vec_write.sel  = VEC_W;
      vec_write.addr = w_cnt;
      vec_write.data = W_IN;
    end else if (e_take) begin
      vec_write.sel  = VEC_E;
      vec_write.addr = e_cnt;
      vec_write.data = E_IN;
    end else begin
      vec_write.sel  = VEC_V;
      vec_write.addr = v_cnt;
      vec_write.data = V_IN;
    end
  end

  // Row pulse restarts the column, same-cycle element sees the new row
  assign row_start  = in_update && M_IN_J_ENABLE;
  assign cur_j      = row_start ? (first_row ? '0 : row_idx + 1'b1) : row_idx;
  assign cur_k      = row_start ? '0 : col_idx;
  // Elements past N*W are dropped
  assign elem_valid = in_update && M_IN_K_ENABLE && (elem_cnt != elem_total);
  assign last_issue = elem_valid && (elem_cnt == elem_total - 1'b1);

  always_comb begin
    element.valid     = elem_valid;
    element.row_start = row_start;
    element.m         = M_IN;
    element.j         = cur_j;
    element.k         = cur_k;
  end

  // Last output of the transaction
  assign READY = last_pipe[1] && out_done;

  ////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE_STATE;
      size_n    <= '0;
      size_w    <= '0;
      w_cnt     <= '0;
      e_cnt     <= '0;
      v_cnt     <= '0;
      row_idx   <= '0;
      col_idx   <= '0;
      first_row <= 1'b1;
      elem_cnt  <= '0;
      last_pipe <= '0;
    end else begin
      last_pipe <= {last_pipe[0], last_issue};
      case (state)
        IDLE_STATE: begin
          if (START) begin
            size_n    <= SIZE_N_IN;
            size_w    <= SIZE_W_IN;
            w_cnt     <= '0;
            e_cnt     <= '0;
            v_cnt     <= '0;
            row_idx   <= '0;
            col_idx   <= '0;
            first_row <= 1'b1;
            elem_cnt  <= '0;
            state     <= LOAD_STATE;
          end
        end
        LOAD_STATE: begin
          if (w_take) w_cnt <= w_cnt + 1'b1;
          if (e_take) e_cnt <= e_cnt + 1'b1;
          if (v_take) v_cnt <= v_cnt + 1'b1;
          if (load_done) state <= UPDATE_STATE;
        end
        UPDATE_STATE: begin
          if (row_start) begin
            row_idx   <= cur_j;
            first_row <= 1'b0;
          end
          if (elem_valid) begin
            col_idx  <= cur_k + 1'b1;
            elem_cnt <= elem_cnt + 1'b1;
          end else if (row_start) begin
            col_idx <= '0;
          end
          if (READY) state <= IDLE_STATE;
        end
        default: state <= IDLE_STATE;
      endcase
    end
  end

endmodule

// ==== src/dnc_vector_buffer.sv ====
// Vector buffer of the DNC memory-update block
//   Register arrays for the write weighting w and the
//   erase and write vectors e and v
//   One indexed write port, combinational indexed reads

`timescale 1ns/1ps

module dnc_vector_buffer
  import dnc_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,

  input  vec_write_t vec_write,
  input  index_t     rd_j,
  input  index_t     rd_k,

  output data_t      w_val,
  output data_t      e_val,
  output data_t      v_val
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // w indexed by row, e and v by column
  data_t w_mem [MAX_N];
  data_t e_mem [MAX_W];
  data_t v_mem [MAX_W];

  logic [ROW_ADDR_W-1:0] wr_row;
  logic [COL_ADDR_W-1:0] wr_col;

  assign wr_row = vec_write.addr[ROW_ADDR_W-1:0];
  assign wr_col = vec_write.addr[COL_ADDR_W-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_N; i++) begin
        w_mem[i] <= '0;
      end
      for (int i = 0; i < MAX_W; i++) begin
        e_mem[i] <= '0;
        v_mem[i] <= '0;
      end
    end else if (vec_write.wr) begin
      // Select field picks the array
      case (vec_write.sel)
        VEC_W:   w_mem[wr_row] <= vec_write.data;
        VEC_E:   e_mem[wr_col] <= vec_write.data;
        VEC_V:   v_mem[wr_col] <= vec_write.data;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Reads
  ////////////////////////////////////////////////////////////

  // Same cycle as the element they serve
  assign w_val = w_mem[rd_j[ROW_ADDR_W-1:0]];
  assign e_val = e_mem[rd_k[COL_ADDR_W-1:0]];
  assign v_val = v_mem[rd_k[COL_ADDR_W-1:0]];

endmodule

// ==== src/dnc_erase_write_unit.sv ====
// Erase and write unit of the DNC memory-update block
//   Stage one: erase factor 1 - w*e and add term w*v
//   Stage two: M*factor + add term, output enables
//   All products floored Q8.8, wrapped to 16 bits

`timescale 1ns/1ps

module dnc_erase_write_unit
  import dnc_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,

  input  element_t element,
  input  data_t    w_val,
  input  data_t    e_val,
  input  data_t    v_val,

  output data_t    M_OUT,
  output logic     M_OUT_J_ENABLE,
  output logic     M_OUT_K_ENABLE
);

  // Exact product, arithmetic shift floors, top bits wrap away
  function automatic data_t q_mul(input data_t a, input data_t b);
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    prod    = a * b;
    shifted = prod >>> FRAC_BITS;
    return shifted[DATA_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////////////////////////

  logic  s1_valid;
  logic  s1_row_start;
  data_t s1_m;
  data_t s1_factor;
  data_t s1_add;

  // Valid chain
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid     <= 1'b0;
      s1_row_start <= 1'b0;
    end else begin
      s1_valid     <= element.valid;
      s1_row_start <= element.row_start;
    end
  end

  // Payload, loaded only with a live element
  always_ff @(posedge CLK) begin
    if (element.valid) begin
      s1_m      <= element.m;
      s1_factor <= data_t'(ONE_Q) - q_mul(w_val, e_val);
      s1_add    <= q_mul(w_val, v_val);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      M_OUT          <= '0;
      M_OUT_J_ENABLE <= 1'b0;
      M_OUT_K_ENABLE <= 1'b0;
    end else begin
      M_OUT_J_ENABLE <= s1_row_start;
      M_OUT_K_ENABLE <= s1_valid;
      // Holds the last result between elements
      if (s1_valid) begin
        M_OUT <= q_mul(s1_m, s1_factor) + s1_add;
      end
    end
  end

endmodule

// ==== src/dnc_memory_matrix.sv ====
// Top level of the DNC memory-update block
//   M(j,k) <= M(j,k)*(1 - w(j)*e(k)) + w(j)*v(k)
//   Control FSM, vector buffer and erase/write pipeline

`timescale 1ns/1ps

module dnc_memory_matrix
  import dnc_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,

  // Control
  input  logic   START,
  output logic   READY,

  input  logic   W_IN_J_ENABLE,
  input  logic   E_IN_K_ENABLE,
  input  logic   V_IN_K_ENABLE,
  input  logic   M_IN_J_ENABLE,
  input  logic   M_IN_K_ENABLE,
  output logic   M_OUT_J_ENABLE,
  output logic   M_OUT_K_ENABLE,

  // Data
  input  data_t  W_IN,
  input  data_t  E_IN,
  input  data_t  V_IN,
  input  data_t  M_IN,
  input  index_t SIZE_N_IN,
  input  index_t SIZE_W_IN,
  output data_t  M_OUT
);

  vec_write_t vec_write;
  element_t   element;
  data_t      w_val;
  data_t      e_val;
  data_t      v_val;

  dnc_matrix_ctrl ctrl_inst (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .W_IN_J_ENABLE (W_IN_J_ENABLE),
    .E_IN_K_ENABLE (E_IN_K_ENABLE),
    .V_IN_K_ENABLE (V_IN_K_ENABLE),
    .M_IN_J_ENABLE (M_IN_J_ENABLE),
    .M_IN_K_ENABLE (M_IN_K_ENABLE),
    .W_IN          (W_IN),
    .E_IN          (E_IN),
    .V_IN          (V_IN),
    .M_IN          (M_IN),
    .SIZE_N_IN     (SIZE_N_IN),
    .SIZE_W_IN     (SIZE_W_IN),
    .out_done      (M_OUT_K_ENABLE),
    .vec_write     (vec_write),
    .element       (element),
    .READY         (READY)
  );

  // Element coordinates address the vectors
  dnc_vector_buffer buffer_inst (
    .CLK       (CLK),
    .RST       (RST),
    .vec_write (vec_write),
    .rd_j      (element.j),
    .rd_k      (element.k),
    .w_val     (w_val),
    .e_val     (e_val),
    .v_val     (v_val)
  );

  dnc_erase_write_unit unit_inst (
    .CLK            (CLK),
    .RST            (RST),
    .element        (element),
    .w_val          (w_val),
    .e_val          (e_val),
    .v_val          (v_val),
    .M_OUT          (M_OUT),
    .M_OUT_J_ENABLE (M_OUT_J_ENABLE),
    .M_OUT_K_ENABLE (M_OUT_K_ENABLE)
  );

endmodule

// ==== bench/dnc_memory_matrix_props.sv ====
// Concurrent assertions on the DNC memory-update top level
//   READY is a single-cycle pulse
//   Output enables only two cycles after their input enables
//   Quiet outputs during reset

`timescale 1ns/1ps

module dnc_memory_matrix_props (
  input logic CLK,
  input logic RST,
  input logic READY,
  input logic M_IN_J_ENABLE,
  input logic M_IN_K_ENABLE,
  input logic M_OUT_J_ENABLE,
  input logic M_OUT_K_ENABLE
);

  // Never two cycles in a row
  ready_single_pulse: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else $error("READY stayed high for more than one cycle");

  // Every output element traces back to an input element
  k_out_from_in: assert property (
    @(posedge CLK) disable iff (RST) M_OUT_K_ENABLE |-> $past(M_IN_K_ENABLE, 2)
  ) else $error("Output element without an input element two cycles before");

  // Same for row starts
  j_out_from_in: assert property (
    @(posedge CLK) disable iff (RST) M_OUT_J_ENABLE |-> $past(M_IN_J_ENABLE, 2)
  ) else $error("Row output without a row input two cycles before");

  reset_quiet: assert property (
    @(posedge CLK) RST |-> (!READY && !M_OUT_J_ENABLE && !M_OUT_K_ENABLE)
  ) else $error("Output strobe high during reset");

endmodule

bind dnc_memory_matrix dnc_memory_matrix_props props_inst (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .M_IN_J_ENABLE  (M_IN_J_ENABLE),
  .M_IN_K_ENABLE  (M_IN_K_ENABLE),
  .M_OUT_J_ENABLE (M_OUT_J_ENABLE),
  .M_OUT_K_ENABLE (M_OUT_K_ENABLE)
);

// ==== bench/dnc_memory_matrix_tb.sv ====
// Testbench for the DNC memory-update block
//   Seeded random sizes, vectors and matrices
//   Queue model of the Q8.8 erase/write rule
//   Output monitor with latency, row count and READY checks
//   Erase extremes, back-to-back and ignored strobe runs

`timescale 1ns/1ps

module dnc_memory_matrix_tb
  import dnc_pkg::*;
();

  logic   CLK;
  logic   RST;
  logic   START;
  logic   READY;
  logic   W_IN_J_ENABLE;
  logic   E_IN_K_ENABLE;
  logic   V_IN_K_ENABLE;
  logic   M_IN_J_ENABLE;
  logic   M_IN_K_ENABLE;
  logic   M_OUT_J_ENABLE;
  logic   M_OUT_K_ENABLE;
  data_t  W_IN;
  data_t  E_IN;
  data_t  V_IN;
  data_t  M_IN;
  data_t  M_OUT;
  index_t SIZE_N_IN;
  index_t SIZE_W_IN;

  // Bench state
  integer seed;
  int     cycle = 0;
  int     err_data;
  int     err_index;
  int     err_flag;
  int     err_other;
  logic   started;
  logic   hung;
  string  test_name;
  int     elem_total;
  int     out_cnt;
  int     rows_seen;
  int     ready_cnt;
  data_t  exp_q[$];
  int     k_stamp_q[$];
  int     j_stamp_q[$];
  data_t  w_vec[MAX_N];
  data_t  e_vec[MAX_W];
  data_t  v_vec[MAX_W];

  dnc_memory_matrix dnc_memory_matrix_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      err_data++;
      $display("ERR %s expected %0d (0x%h) actual %0d (0x%h)", name, exp, exp, act, act);
    end
  endtask

  task automatic check_index(input string name, input index_t exp, input index_t act);
    if (exp !== act) begin
      err_index++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      err_flag++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Q8.8 product, floored, wrapped to 16 bits
  function automatic data_t floor_mul(input data_t a, input data_t b);
    longint prod;
    longint quot;
    prod = longint'(a) * longint'(b);
    quot = prod / ONE_Q;
    // Division rounds toward zero, step down on a negative remainder
    if ((prod < 0) && ((prod % ONE_Q) != 0)) begin
      quot = quot - 1;
    end
    return quot[DATA_W-1:0];
  endfunction

  function automatic data_t model_element(input data_t m, input data_t w,
                                          input data_t e, input data_t v);
    data_t factor;
    factor = data_t'(ONE_Q - floor_mul(w, e));
    return data_t'(floor_mul(m, factor) + floor_mul(w, v));
  endfunction

  function automatic data_t rand_data();
    return data_t'($random(seed));
  endfunction

  function automatic int rand_below(input int limit);
    return int'({$random(seed)} % limit);
  endfunction

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin : monitor
    int stamp;
    if (!started) begin
      check_flag("reset READY", 1'b0, READY);
      check_flag("reset M_OUT_J_ENABLE", 1'b0, M_OUT_J_ENABLE);
      check_flag("reset M_OUT_K_ENABLE", 1'b0, M_OUT_K_ENABLE);
      check_data("reset M_OUT", '0, M_OUT);
    end
    if (M_OUT_J_ENABLE) begin
      rows_seen++;
      if (j_stamp_q.size() == 0) begin
        err_other++;
        $display("%s: row enable on the output with no row started", test_name);
      end else begin
        stamp = j_stamp_q.pop_front();
        if ((cycle - stamp) != 2) begin
          err_other++;
          $display("%s: row output came %0d cycles after its input instead of 2",
                   test_name, cycle - stamp);
        end
      end
    end
    if (M_OUT_K_ENABLE) begin
      if (exp_q.size() == 0) begin
        err_other++;
        $display("%s: element on the output with no element sent", test_name);
      end else begin
        check_data($sformatf("%s elem %0d", test_name, out_cnt), exp_q.pop_front(), M_OUT);
        stamp = k_stamp_q.pop_front();
        if ((cycle - stamp) != 2) begin
          err_other++;
          $display("%s: element output came %0d cycles after its input instead of 2",
                   test_name, cycle - stamp);
        end
        out_cnt++;
      end
    end
    // READY only with the last element
    check_flag($sformatf("%s READY", test_name),
               M_OUT_K_ENABLE && (out_cnt == elem_total), READY);
    if (READY) ready_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Inputs change 5 ns after the rising edge, strobes default low
  task automatic next_cycle();
    @(posedge CLK);
    #5;
    START         = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    E_IN_K_ENABLE = 1'b0;
    V_IN_K_ENABLE = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
  endtask

  task automatic drive_junk_m();
    M_IN_J_ENABLE = (rand_below(2) == 1);
    M_IN_K_ENABLE = 1'b1;
    M_IN          = rand_data();
  endtask

  task automatic drive_junk_vec();
    W_IN_J_ENABLE = 1'b1;
    E_IN_K_ENABLE = (rand_below(2) == 1);
    V_IN_K_ENABLE = 1'b1;
    W_IN          = rand_data();
    E_IN          = rand_data();
    V_IN          = rand_data();
  endtask

  // Mode 1 sets w and e to 1.0, mode 2 clears w
  task automatic load_vectors(input int n_rows, input int n_cols, input int mode,
                              input bit gaps, input bit junk);
    int wi;
    int ei;
    int vi;
    int pick;
    for (int j = 0; j < n_rows; j++) begin
      case (mode)
        1:       w_vec[j] = data_t'(ONE_Q);
        2:       w_vec[j] = '0;
        default: w_vec[j] = rand_data();
      endcase
    end
    for (int k = 0; k < n_cols; k++) begin
      e_vec[k] = (mode == 1) ? data_t'(ONE_Q) : rand_data();
      v_vec[k] = rand_data();
    end
    wi = 0;
    ei = 0;
    vi = 0;
    while ((wi < n_rows) || (ei < n_cols) || (vi < n_cols)) begin
      next_cycle();
      if (gaps && (rand_below(4) == 0)) begin
        // Matrix strobes before the vectors are full
        if (junk) drive_junk_m();
      end else begin
        pick = rand_below(3);
        while (((pick == 0) && (wi == n_rows)) || ((pick == 1) && (ei == n_cols)) ||
               ((pick == 2) && (vi == n_cols))) begin
          pick = (pick + 1) % 3;
        end
        case (pick)
          0: begin
            W_IN_J_ENABLE = 1'b1;
            W_IN          = w_vec[wi];
            wi++;
          end
          1: begin
            E_IN_K_ENABLE = 1'b1;
            E_IN          = e_vec[ei];
            ei++;
          end
          default: begin
            V_IN_K_ENABLE = 1'b1;
            V_IN          = v_vec[vi];
            vi++;
          end
        endcase
      end
    end
    // FSM moves to UPDATE_STATE a cycle after the last write
    next_cycle();
    next_cycle();
  endtask

  task automatic stream_matrix(input int n_rows, input int n_cols,
                               input bit gaps, input bit junk);
    data_t m;
    for (int j = 0; j < n_rows; j++) begin
      next_cycle();
      M_IN_J_ENABLE = 1'b1;
      j_stamp_q.push_back(cycle);
      for (int k = 0; k < n_cols; k++) begin
        // Without gaps the row pulse shares a cycle with the first element
        if (gaps || (k > 0)) begin
          next_cycle();
        end
        while (gaps && (rand_below(3) == 0)) begin
          // Vector strobes in UPDATE_STATE
          if (junk) drive_junk_vec();
          next_cycle();
        end
        m             = rand_data();
        M_IN_K_ENABLE = 1'b1;
        M_IN          = m;
        exp_q.push_back(model_element(m, w_vec[j], e_vec[k], v_vec[k]));
        k_stamp_q.push_back(cycle);
      end
    end
    next_cycle();
  endtask

  task automatic run_transaction(input int t);
    int mode;
    bit b2b;
    bit junk;
    int n_rows;
    int n_cols;
    int waited;
    mode       = (t == 2) ? 1 : ((t == 3) ? 2 : 0);
    b2b        = (t == 4) || (t == 5);
    junk       = ((t % 2) == 0) && !b2b;
    n_rows     = 1 + rand_below(MAX_N);
    n_cols     = 1 + rand_below(MAX_W);
    test_name  = $sformatf("run%0d_mode%0d_b2b%0d", t, mode, b2b);
    elem_total = n_rows * n_cols;
    out_cnt    = 0;
    rows_seen  = 0;
    ready_cnt  = 0;
    // Strobes in IDLE_STATE change nothing
    repeat (2) begin
      next_cycle();
      if (junk) begin
        drive_junk_m();
        drive_junk_vec();
      end
    end
    next_cycle();
    START     = 1'b1;
    SIZE_N_IN = index_t'(n_rows);
    SIZE_W_IN = index_t'(n_cols);
    started   = 1'b1;
    next_cycle();
    load_vectors(n_rows, n_cols, mode, !b2b, junk);
    stream_matrix(n_rows, n_cols, !b2b, junk);
    waited = 0;
    while ((ready_cnt == 0) && (waited < 50)) begin
      next_cycle();
      waited++;
    end
    if (ready_cnt == 0) begin
      $display("Timeout: READY did not rise within 50 cycles in %s", test_name);
      hung = 1'b1;
    end else begin
      // One more cycle shows a stretched READY
      next_cycle();
      check_index({test_name, " rows"}, index_t'(n_rows), index_t'(rows_seen));
      check_index({test_name, " ready pulses"}, index_t'(1), index_t'(ready_cnt));
      if (exp_q.size() != 0) begin
        err_other++;
        $display("%s ended with %0d elements never output", test_name, exp_q.size());
      end
    end
  endtask

  initial begin
    seed          = 32'he641_0218;
    err_data      = 0;
    err_index     = 0;
    err_flag      = 0;
    err_other     = 0;
    started       = 1'b0;
    hung          = 1'b0;
    test_name     = "reset";
    elem_total    = 0;
    out_cnt       = 0;
    rows_seen     = 0;
    ready_cnt     = 0;
    START         = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    E_IN_K_ENABLE = 1'b0;
    V_IN_K_ENABLE = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
    W_IN          = '0;
    E_IN          = '0;
    V_IN          = '0;
    M_IN          = '0;
    SIZE_N_IN     = '0;
    SIZE_W_IN     = '0;
    RST           = 1'b1;
    repeat (8) @(posedge CLK);
    #5;
    RST = 1'b0;
    repeat (3) next_cycle();
    for (int t = 0; (t < 8) && !hung; t++) begin
      run_transaction(t);
    end
    $display("Error counts: data %0d, index %0d, flag %0d, other %0d",
             err_data, err_index, err_flag, err_other);
    if (hung || ((err_data + err_index + err_flag + err_other) != 0)) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/dnc_pkg.sv
src/dnc_matrix_ctrl.sv
src/dnc_vector_buffer.sv
src/dnc_erase_write_unit.sv
src/dnc_memory_matrix.sv
bench/dnc_memory_matrix_props.sv
bench/dnc_memory_matrix_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DNC memory-update testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

echo "Building simulation"
verilator --binary --timing --assert -Wno-fatal \
  --top-module dnc_memory_matrix_tb \
  -Mdir "$BUILD_DIR" -o sim \
  -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
  echo "Simulation result: pass"
  exit 0
fi
echo "Simulation result: fail, see $LOG"
exit 1
